// File: hdl/fb_pkg.sv
package fb_pkg;

    // buffer pool
    localparam int NUM_FRAMES = 3;
    localparam int BUF_IDX_W  = 2;

    // memory word address
    localparam int ADDR_W = 21;

    // camera frame geometry
    localparam int FRAME_WIDTH  = 640;
    localparam int FRAME_HEIGHT = 480;
    localparam int MEM_BURST    = 32;

    // one spare burst between frames
    localparam int FRAME_STRIDE = FRAME_WIDTH * FRAME_HEIGHT + MEM_BURST;

    typedef enum logic [0:0] {
        OP_ACQUIRE,
        OP_RELEASE
    } fb_op_t;

    typedef enum logic [0:0] {
        ST_OK,
        ST_BAD_SEQUENCE
    } fb_status_t;

    typedef enum logic [2:0] {
        BUF_AVAILABLE,
        BUF_WRITE_BUSY,
        BUF_READ_BUSY,
        BUF_DISPLAYED,
        BUF_UPDATED
    } buf_state_t;

    // client port handshake
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_PENDING,
        HS_WAIT_DONE,
        HS_ACK
    } hs_state_t;

endpackage

// File: hdl/client_handshake.sv
`timescale 1ns/1ps

module client_handshake import fb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_i,
    input  fb_op_t    op_i,
    input  logic      taken_i,
    input  logic      done_i,
    output logic      pending_o,
    output fb_op_t    op_o,
    output logic      ack_o
);

    hs_state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HS_IDLE;
            op_o  <= OP_ACQUIRE;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (req_i) begin
                        op_o  <= op_i;
                        state <= HS_PENDING;
                    end
                end
                HS_PENDING: begin
                    // stays here while the other client is served
                    if (taken_i) begin
                        state <= HS_WAIT_DONE;
                    end
                end
                HS_WAIT_DONE: begin
                    if (done_i) begin
                        state <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    // client may hold req as long as it likes
                    if (!req_i) begin
                        state <= HS_IDLE;
                    end
                end
                default: begin
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    assign pending_o = (state == HS_PENDING);
    assign ack_o     = (state == HS_ACK);

endmodule

// File: hdl/request_decode.sv
`timescale 1ns/1ps

module request_decode import fb_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   init_done_i,
    input  logic   wr_pending_i,
    input  fb_op_t wr_op_i,
    input  logic   rd_pending_i,
    input  fb_op_t rd_op_i,
    output logic   wr_taken_o,
    output logic   rd_taken_o,
    output logic   cmd_valid_o,
    output logic   cmd_reader_o,
    output fb_op_t cmd_op_o
);

    logic init_seen;
    logic rd_first;
    logic grant_wr;
    logic grant_rd;

    always_comb begin
        grant_wr = 1'b0;
        grant_rd = 1'b0;
        // memory not ready, hold everyone off
        if (init_seen) begin
            if (wr_pending_i && rd_pending_i) begin
                grant_rd = rd_first;
                grant_wr = !rd_first;
            end else begin
                grant_wr = wr_pending_i;
                grant_rd = rd_pending_i;
            end
        end
    end

    assign wr_taken_o = grant_wr;
    assign rd_taken_o = grant_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_seen    <= 1'b0;
            rd_first     <= 1'b0;
            cmd_valid_o  <= 1'b0;
            cmd_reader_o <= 1'b0;
            cmd_op_o     <= OP_ACQUIRE;
        end else begin
            init_seen   <= init_seen | init_done_i;
            cmd_valid_o <= grant_wr | grant_rd;
            if (grant_wr || grant_rd) begin
                // the other client wins the next tie
                rd_first     <= grant_wr;
                cmd_reader_o <= grant_rd;
                cmd_op_o     <= grant_rd ? rd_op_i : wr_op_i;
            end
        end
    end

endmodule

// File: hdl/buffer_table.sv
`timescale 1ns/1ps

module buffer_table import fb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid_i,
    input  logic                 cmd_reader_i,
    input  fb_op_t               cmd_op_i,
    output logic                 res_valid_o,
    output logic                 res_reader_o,
    output fb_status_t           res_status_o,
    output logic [BUF_IDX_W-1:0] res_index_o
);

    buf_state_t buf_state [NUM_FRAMES];

    logic                 wr_owned;
    logic                 rd_owned;
    logic [BUF_IDX_W-1:0] wr_idx;
    logic [BUF_IDX_W-1:0] rd_idx;

    logic                 own;
    logic [BUF_IDX_W-1:0] own_idx;
    logic [BUF_IDX_W:0]   hit_disp;
    logic [BUF_IDX_W:0]   hit_avail;
    logic [BUF_IDX_W:0]   hit_upd;
    logic [BUF_IDX_W-1:0] pick;
    logic                 acquire;
    logic                 bad;

    // msb is the found flag, last match wins so the highest index is taken
    function automatic logic [BUF_IDX_W:0] find_class(input buf_state_t cls);
        logic [BUF_IDX_W:0] hit;
        hit = '0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (buf_state[i] == cls) begin
                hit = {1'b1, BUF_IDX_W'(i)};
            end
        end
        return hit;
    endfunction

    always_comb begin
        hit_disp  = find_class(BUF_DISPLAYED);
        hit_avail = find_class(BUF_AVAILABLE);
        hit_upd   = find_class(BUF_UPDATED);
        own       = cmd_reader_i ? rd_owned : wr_owned;
        own_idx   = cmd_reader_i ? rd_idx : wr_idx;
        acquire   = (cmd_op_i == OP_ACQUIRE);
        bad       = acquire ? own : !own;

        // reader wants the freshest frame, writer the stalest
        if (cmd_reader_i) begin
            if (hit_upd[BUF_IDX_W]) pick = hit_upd[BUF_IDX_W-1:0];
            else if (hit_avail[BUF_IDX_W]) pick = hit_avail[BUF_IDX_W-1:0];
            else pick = hit_disp[BUF_IDX_W-1:0];
        end else begin
            if (hit_disp[BUF_IDX_W]) pick = hit_disp[BUF_IDX_W-1:0];
            else if (hit_avail[BUF_IDX_W]) pick = hit_avail[BUF_IDX_W-1:0];
            else pick = hit_upd[BUF_IDX_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_FRAMES; i++) begin
                buf_state[i] <= BUF_AVAILABLE;
            end
            wr_owned     <= 1'b0;
            rd_owned     <= 1'b0;
            wr_idx       <= '0;
            rd_idx       <= '0;
            res_valid_o  <= 1'b0;
            res_reader_o <= 1'b0;
            res_status_o <= ST_OK;
            res_index_o  <= '0;
        end else begin
            res_valid_o <= cmd_valid_i;
            if (cmd_valid_i) begin
                res_reader_o <= cmd_reader_i;
                res_status_o <= bad ? ST_BAD_SEQUENCE : ST_OK;
                res_index_o  <= (acquire && !bad) ? pick : (own ? own_idx : '0);
            end
            if (cmd_valid_i && !bad) begin
                if (acquire) begin
                    buf_state[pick] <= cmd_reader_i ? BUF_READ_BUSY : BUF_WRITE_BUSY;
                end else begin
                    buf_state[own_idx] <= cmd_reader_i ? BUF_DISPLAYED : BUF_UPDATED;
                end
                if (cmd_reader_i) begin
                    rd_owned <= acquire;
                    rd_idx   <= acquire ? pick : rd_idx;
                end else begin
                    wr_owned <= acquire;
                    wr_idx   <= acquire ? pick : wr_idx;
                end
            end
        end
    end

endmodule

// File: hdl/response_result.sv
`timescale 1ns/1ps

module response_result import fb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 res_valid_i,
    input  logic                 res_reader_i,
    input  fb_status_t           res_status_i,
    input  logic [BUF_IDX_W-1:0] res_index_i,
    output logic                 wr_done_o,
    output logic                 rd_done_o,
    output fb_status_t           wr_status_o,
    output logic [BUF_IDX_W-1:0] wr_index_o,
    output logic [ADDR_W-1:0]    wr_base_addr_o,
    output fb_status_t           rd_status_o,
    output logic [BUF_IDX_W-1:0] rd_index_o,
    output logic [ADDR_W-1:0]    rd_base_addr_o
);

    logic [ADDR_W-1:0] base_addr;

    // frame base in memory words
    assign base_addr = ADDR_W'(res_index_i) * ADDR_W'(FRAME_STRIDE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_done_o      <= 1'b0;
            rd_done_o      <= 1'b0;
            wr_status_o    <= ST_OK;
            wr_index_o     <= '0;
            wr_base_addr_o <= '0;
            rd_status_o    <= ST_OK;
            rd_index_o     <= '0;
            rd_base_addr_o <= '0;
        end else begin
            wr_done_o <= res_valid_i && !res_reader_i;
            rd_done_o <= res_valid_i && res_reader_i;
            if (res_valid_i && !res_reader_i) begin
                wr_status_o    <= res_status_i;
                wr_index_o     <= res_index_i;
                wr_base_addr_o <= base_addr;
            end
            if (res_valid_i && res_reader_i) begin
                rd_status_o    <= res_status_i;
                rd_index_o     <= res_index_i;
                rd_base_addr_o <= base_addr;
            end
        end
    end

endmodule

// File: hdl/frame_buffer_ctrl.sv
`timescale 1ns/1ps

module frame_buffer_ctrl import fb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init_done_i,
    // frame writer
    input  logic                 wr_req_i,
    input  fb_op_t               wr_op_i,
    output logic                 wr_ack_o,
    output fb_status_t           wr_status_o,
    output logic [BUF_IDX_W-1:0] wr_index_o,
    output logic [ADDR_W-1:0]    wr_base_addr_o,
    // frame reader
    input  logic                 rd_req_i,
    input  fb_op_t               rd_op_i,
    output logic                 rd_ack_o,
    output fb_status_t           rd_status_o,
    output logic [BUF_IDX_W-1:0] rd_index_o,
    output logic [ADDR_W-1:0]    rd_base_addr_o
);

    logic                 wr_pending;
    logic                 rd_pending;
    fb_op_t               wr_op;
    fb_op_t               rd_op;
    logic                 wr_taken;
    logic                 rd_taken;
    logic                 wr_done;
    logic                 rd_done;
    logic                 cmd_valid;
    logic                 cmd_reader;
    fb_op_t               cmd_op;
    logic                 res_valid;
    logic                 res_reader;
    fb_status_t           res_status;
    logic [BUF_IDX_W-1:0] res_index;

    client_handshake u_wr_hs (
        .clk(clk), .rst_n(rst_n), .req_i(wr_req_i), .op_i(wr_op_i),
        .taken_i(wr_taken), .done_i(wr_done),
        .pending_o(wr_pending), .op_o(wr_op), .ack_o(wr_ack_o)
    );

    client_handshake u_rd_hs (
        .clk(clk), .rst_n(rst_n), .req_i(rd_req_i), .op_i(rd_op_i),
        .taken_i(rd_taken), .done_i(rd_done),
        .pending_o(rd_pending), .op_o(rd_op), .ack_o(rd_ack_o)
    );

    request_decode u_decode (
        .clk(clk), .rst_n(rst_n), .init_done_i(init_done_i),
        .wr_pending_i(wr_pending), .wr_op_i(wr_op),
        .rd_pending_i(rd_pending), .rd_op_i(rd_op),
        .wr_taken_o(wr_taken), .rd_taken_o(rd_taken),
        .cmd_valid_o(cmd_valid), .cmd_reader_o(cmd_reader), .cmd_op_o(cmd_op)
    );

    buffer_table u_table (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid_i(cmd_valid), .cmd_reader_i(cmd_reader), .cmd_op_i(cmd_op),
        .res_valid_o(res_valid), .res_reader_o(res_reader),
        .res_status_o(res_status), .res_index_o(res_index)
    );

    response_result u_result (
        .clk(clk), .rst_n(rst_n),
        .res_valid_i(res_valid), .res_reader_i(res_reader),
        .res_status_i(res_status), .res_index_i(res_index),
        .wr_done_o(wr_done), .rd_done_o(rd_done),
        .wr_status_o(wr_status_o), .wr_index_o(wr_index_o),
        .wr_base_addr_o(wr_base_addr_o),
        .rd_status_o(rd_status_o), .rd_index_o(rd_index_o),
        .rd_base_addr_o(rd_base_addr_o)
    );

endmodule

// File: tb/fb_props.sv
`timescale 1ns/1ps

module fb_props import fb_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input fb_op_t               cmd_op_i,
    input logic                 res_valid_i,
    input logic                 res_reader_i,
    input fb_status_t           res_status_i,
    input logic [BUF_IDX_W-1:0] res_index_i,
    input buf_state_t           state0_i,
    input buf_state_t           state1_i,
    input buf_state_t           state2_i
);

    logic [NUM_FRAMES-1:0] wr_busy;
    logic [NUM_FRAMES-1:0] rd_busy;
    buf_state_t            res_state;

    assign wr_busy = {state2_i == BUF_WRITE_BUSY, state1_i == BUF_WRITE_BUSY,
                      state0_i == BUF_WRITE_BUSY};
    assign rd_busy = {state2_i == BUF_READ_BUSY, state1_i == BUF_READ_BUSY,
                      state0_i == BUF_READ_BUSY};

    // state of the buffer named in the result
    always_comb begin
        case (res_index_i)
            2'd0:    res_state = state0_i;
            2'd1:    res_state = state1_i;
            default: res_state = state2_i;
        endcase
    end

    function automatic buf_state_t granted_state(input fb_op_t op, input logic reader);
        if (op == OP_ACQUIRE) begin
            return reader ? BUF_READ_BUSY : BUF_WRITE_BUSY;
        end
        return reader ? BUF_DISPLAYED : BUF_UPDATED;
    endfunction

    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_busy))
        else $error("more than one buffer is write-busy");

    a_one_reader: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_busy))
        else $error("more than one buffer is read-busy");

    // an accepted command leaves its buffer in the new state
    a_result_state: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid_i && res_status_i == ST_OK)
            |-> res_state == granted_state($past(cmd_op_i), res_reader_i))
        else $error("buffer state does not match the result just reported");

endmodule

bind buffer_table fb_props u_props (
    .clk(clk), .rst_n(rst_n), .cmd_op_i(cmd_op_i),
    .res_valid_i(res_valid_o), .res_reader_i(res_reader_o),
    .res_status_i(res_status_o), .res_index_i(res_index_o),
    .state0_i(buf_state[0]), .state1_i(buf_state[1]), .state2_i(buf_state[2])
);

// File: tb/tb_frame_buffer_ctrl.sv
`timescale 1ns/1ps

module tb_frame_buffer_ctrl import fb_pkg::*; ();

    localparam logic [31:0] SEED = 32'h84f2a0b4;
    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = NUM_OPS * 20 + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 init_done_i;
    logic                 wr_req;
    logic                 rd_req;
    fb_op_t               wr_op;
    fb_op_t               rd_op;
    logic                 wr_ack;
    logic                 rd_ack;
    fb_status_t           wr_status;
    fb_status_t           rd_status;
    logic [BUF_IDX_W-1:0] wr_index;
    logic [BUF_IDX_W-1:0] rd_index;
    logic [ADDR_W-1:0]    wr_base_addr;
    logic [ADDR_W-1:0]    rd_base_addr;

    // reference model of the buffer table and the arbiter
    buf_state_t m_state [NUM_FRAMES];
    bit         m_owned [2];
    int         m_idx [2];
    bit         m_rd_first;
    int         cycles = 0;

    frame_buffer_ctrl uut (
        .clk(clk), .rst_n(rst_n), .init_done_i(init_done_i),
        .wr_req_i(wr_req), .wr_op_i(wr_op), .wr_ack_o(wr_ack),
        .wr_status_o(wr_status), .wr_index_o(wr_index), .wr_base_addr_o(wr_base_addr),
        .rd_req_i(rd_req), .rd_op_i(rd_op), .rd_ack_o(rd_ack),
        .rd_status_o(rd_status), .rd_index_o(rd_index), .rd_base_addr_o(rd_base_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("no ack from the DUT within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_status(input fb_status_t got, input fb_status_t exp, input string who);
        if (got !== exp) begin
            $display("Fail %0t: %s status %s, expected %s", $time, who, got.name(), exp.name());
            $display("Test failed");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_index(input logic [BUF_IDX_W-1:0] got,
                               input logic [BUF_IDX_W-1:0] exp, input string who);
        if (got !== exp) begin
            $display("Fail %0t: %s index %0d, expected %0d", $time, who, got, exp);
            $display("Test failed");
            $fatal(1, "index mismatch");
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp, input string who);
        if (got !== exp) begin
            $display("Fail %0t: %s base address %0h, expected %0h", $time, who, got, exp);
            $display("Test failed");
            $fatal(1, "address mismatch");
        end
    endtask

    // class order per client, highest index wins inside a class
    function automatic int pick_buffer(input bit reader);
        buf_state_t order [3];
        if (reader) begin
            order = '{BUF_UPDATED, BUF_AVAILABLE, BUF_DISPLAYED};
        end else begin
            order = '{BUF_DISPLAYED, BUF_AVAILABLE, BUF_UPDATED};
        end
        for (int c = 0; c < 3; c++) begin
            for (int i = NUM_FRAMES - 1; i >= 0; i--) begin
                if (m_state[i] == order[c]) begin
                    return i;
                end
            end
        end
        return 0;
    endfunction

    function automatic void model_apply(input bit reader, input fb_op_t op,
                                        output fb_status_t st, output int idx);
        int r;
        r = reader ? 1 : 0;
        m_rd_first = !reader;
        st = ST_OK;
        if (op == OP_ACQUIRE) begin
            if (m_owned[r]) begin
                st = ST_BAD_SEQUENCE;
                idx = m_idx[r];
            end else begin
                idx = pick_buffer(reader);
                m_state[idx] = reader ? BUF_READ_BUSY : BUF_WRITE_BUSY;
                m_owned[r] = 1'b1;
                m_idx[r] = idx;
            end
        end else if (!m_owned[r]) begin
            st = ST_BAD_SEQUENCE;
            idx = 0;
        end else begin
            idx = m_idx[r];
            m_state[idx] = reader ? BUF_DISPLAYED : BUF_UPDATED;
            m_owned[r] = 1'b0;
        end
    endfunction

    function automatic logic ack_of(input bit reader);
        return reader ? rd_ack : wr_ack;
    endfunction

    task automatic check_client(input bit reader, input fb_status_t st, input int idx);
        logic [BUF_IDX_W-1:0] exp_idx;
        logic [ADDR_W-1:0]    exp_addr;
        exp_idx = BUF_IDX_W'(idx);
        exp_addr = ADDR_W'(idx * FRAME_STRIDE);
        if (reader) begin
            check_status(rd_status, st, "reader");
            check_index(rd_index, exp_idx, "reader");
            check_addr(rd_base_addr, exp_addr, "reader");
        end else begin
            check_status(wr_status, st, "writer");
            check_index(wr_index, exp_idx, "writer");
            check_addr(wr_base_addr, exp_addr, "writer");
        end
    endtask

    task automatic raise_req(input bit reader, input fb_op_t op);
        @(negedge clk);
        if (reader) begin
            rd_op = op;
            rd_req = 1'b1;
        end else begin
            wr_op = op;
            wr_req = 1'b1;
        end
    endtask

    task automatic wait_ack(input bit reader);
        while (!ack_of(reader)) begin
            @(negedge clk);
        end
    endtask

    // hold req past ack, outputs must not move
    task automatic hold_and_release(input bit reader, input int hold,
                                    input fb_status_t st, input int idx);
        repeat (hold) begin
            @(negedge clk);
            if (!ack_of(reader)) begin
                abort_run("ack dropped while req was still high");
            end
            check_client(reader, st, idx);
        end
        if (reader) begin
            rd_req = 1'b0;
        end else begin
            wr_req = 1'b0;
        end
        while (ack_of(reader)) begin
            @(negedge clk);
        end
    endtask

    task automatic run_op(input bit reader, input fb_op_t op, input int hold);
        fb_status_t st;
        int         idx;
        raise_req(reader, op);
        wait_ack(reader);
        model_apply(reader, op, st, idx);
        check_client(reader, st, idx);
        hold_and_release(reader, hold, st, idx);
    endtask

    initial begin
        logic [31:0] seed_out;
        fb_status_t  st;
        fb_status_t  st2;
        int          idx;
        int          idx2;
        bit          first;
        seed_out = $urandom(SEED);
        rst_n = 1'b0;
        init_done_i = 1'b0;
        wr_req = 1'b0;
        rd_req = 1'b0;
        wr_op = OP_ACQUIRE;
        rd_op = OP_ACQUIRE;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            m_state[i] = BUF_AVAILABLE;
        end
        m_owned = '{1'b0, 1'b0};
        m_idx = '{0, 0};
        m_rd_first = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // memory not ready yet
        raise_req(1'b0, OP_ACQUIRE);
        repeat (12) begin
            @(negedge clk);
            if (wr_ack || rd_ack) begin
                abort_run("ack raised before init done");
            end
        end
        init_done_i = 1'b1;
        wait_ack(1'b0);
        model_apply(1'b0, OP_ACQUIRE, st, idx);
        check_client(1'b0, st, idx);
        check_index(wr_index, BUF_IDX_W'(2), "first writer acquire");
        hold_and_release(1'b0, 0, st, idx);
        run_op(1'b1, OP_ACQUIRE, 0);

        // double acquire, then release without ownership
        run_op(1'b0, OP_ACQUIRE, 1);
        run_op(1'b0, OP_RELEASE, 0);
        run_op(1'b0, OP_RELEASE, 2);
        run_op(1'b1, OP_RELEASE, 0);

        // both clients in the same cycle
        @(negedge clk);
        wr_op = OP_ACQUIRE;
        rd_op = OP_ACQUIRE;
        wr_req = 1'b1;
        rd_req = 1'b1;
        while (!(wr_ack && rd_ack)) begin
            @(negedge clk);
        end
        first = m_rd_first;
        model_apply(first, OP_ACQUIRE, st, idx);
        model_apply(!first, OP_ACQUIRE, st2, idx2);
        check_client(first, st, idx);
        check_client(!first, st2, idx2);
        if (wr_index == rd_index) begin
            abort_run("writer and reader were given the same buffer");
        end
        wr_req = 1'b0;
        rd_req = 1'b0;
        while (wr_ack || rd_ack) begin
            @(negedge clk);
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            run_op($urandom_range(1, 0) == 1,
                   ($urandom_range(1, 0) == 1) ? OP_RELEASE : OP_ACQUIRE,
                   int'($urandom_range(4, 0)));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: files.f
hdl/fb_pkg.sv
hdl/client_handshake.sv
hdl/request_decode.sv
hdl/buffer_table.sv
hdl/response_result.sv
hdl/frame_buffer_ctrl.sv
tb/fb_props.sv
tb/tb_frame_buffer_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the frame buffer controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module tb_frame_buffer_ctrl -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0
